//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       := tb_top
FILELIST  := sources.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) logic/mem_defines.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- logic/byte_lane.sv
`include "mem_defines.svh"

module byte_lane (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               re_i,
  input  logic [`ADDR_W-3:0] rd_idx_i,
  input  logic               we_i,
  input  logic [`ADDR_W-3:0] wr_idx_i,
  input  logic [7:0]         wdata_i,
  output logic [7:0]         rdata_o
);

  logic [7:0] mem_r [`MEM_WORDS];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `MEM_WORDS; i++) begin
        mem_r[i] <= '0;
      end
      rdata_o <= '0;
    end else begin
      if (we_i) begin
        mem_r[wr_idx_i] <= wdata_i;
      end
      // read data holds until the next accepted request
      if (re_i) begin
        rdata_o <= mem_r[rd_idx_i];
      end
    end
  end

endmodule

//--- logic/mem_defines.svh
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// number of 32-bit words in the scratchpad
`define MEM_WORDS 64

// byte address width, covers MEM_WORDS * 4 bytes
`define ADDR_W 8

`define DATA_W 32

// byte lanes per word
`define LANES 4

`endif

//--- logic/mem_pkg.sv
`include "mem_defines.svh"

package mem_pkg;

  // bit 4 marks the atomics, bit 3 the stores
  typedef enum logic [4:0] {
    LB      = 5'h00,
    LH      = 5'h01,
    LW      = 5'h02,
    LBU     = 5'h04,
    LHU     = 5'h05,
    LM      = 5'h07,
    SB      = 5'h08,
    SH      = 5'h09,
    SW      = 5'h0a,
    SM      = 5'h0b,
    AMOSWAP = 5'h10,
    AMOADD  = 5'h11,
    AMOXOR  = 5'h12,
    AMOAND  = 5'h13,
    AMOOR   = 5'h14,
    AMOMIN  = 5'h15,
    AMOMAX  = 5'h16,
    AMOMINU = 5'h17,
    AMOMAXU = 5'h18
  } opcode_e;

  // one data word, seen whole or as byte lanes
  typedef union packed {
    logic [`DATA_W-1:0]     word;
    logic [`LANES-1:0][7:0] lanes;
  } word_u;

endpackage

//--- logic/req_decode.sv
`include "mem_defines.svh"

module req_decode (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               v_i,
  input  mem_pkg::opcode_e   opcode_i,
  input  logic [`ADDR_W-1:0] addr_i,
  input  logic [`DATA_W-1:0] data_i,
  input  logic [`LANES-1:0]  mask_i,
  input  logic               stall_i,
  input  logic               amo_we_i,
  input  logic [`ADDR_W-3:0] amo_idx_i,
  input  logic [`DATA_W-1:0] amo_word_i,
  output logic               ready_o,
  output logic               accept_o,
  output logic               lane_we_o [`LANES],
  output mem_pkg::word_u     lane_wdata_o,
  output logic [`ADDR_W-3:0] rd_idx_o,
  output logic [`ADDR_W-3:0] wr_idx_o,
  output logic [`ADDR_W-3:0] idx_o,
  output mem_pkg::opcode_e   op_o,
  output logic [1:0]         off_o,
  output logic [`LANES-1:0]  mask_o,
  output logic [`DATA_W-1:0] reqdata_o
);

  logic              live_r;
  logic              is_store;
  logic [`LANES-1:0] st_mask;
  mem_pkg::word_u    src_data;
  mem_pkg::word_u    st_data;

  // ready comes up the first cycle after reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      live_r <= 1'b0;
    end else begin
      live_r <= 1'b1;
    end
  end

  assign ready_o  = live_r & ~stall_i;
  assign accept_o = v_i & ready_o;
  assign rd_idx_o = addr_i[`ADDR_W-1:2];
  assign src_data = data_i;

  // store byte enables, halfword and byte data copied to every lane they may hit
  always_comb begin
    is_store = 1'b1;
    st_mask  = '0;
    st_data  = src_data;
    case (opcode_i)
      mem_pkg::SW: st_mask = '1;
      mem_pkg::SH: begin
        st_mask = addr_i[1] ? 4'b1100 : 4'b0011;
        for (int i = 0; i < `LANES; i++) begin
          st_data.lanes[i] = src_data.lanes[i % 2];
        end
      end
      mem_pkg::SB: begin
        st_mask = `LANES'(1) << addr_i[1:0];
        for (int i = 0; i < `LANES; i++) begin
          st_data.lanes[i] = src_data.lanes[0];
        end
      end
      mem_pkg::SM: st_mask = mask_i;
      default: is_store = 1'b0;
    endcase
  end

  // atomic write-back takes the write port over a store
  always_comb begin
    for (int i = 0; i < `LANES; i++) begin
      lane_we_o[i] = amo_we_i | (accept_o & is_store & st_mask[i]);
    end
    if (amo_we_i) begin
      lane_wdata_o = amo_word_i;
      wr_idx_o     = amo_idx_i;
    end else begin
      lane_wdata_o = st_data;
      wr_idx_o     = rd_idx_o;
    end
  end

  // fields that travel alongside the lane read
  always_ff @(posedge clk_i) begin
    if (accept_o) begin
      idx_o     <= rd_idx_o;
      op_o      <= opcode_i;
      off_o     <= addr_i[1:0];
      mask_o    <= mask_i;
      reqdata_o <= data_i;
    end
  end

  // the in-flight atomic holds ready low, so no store lands on its write-back
  a_store_vs_amo: assert property (@(posedge clk_i) disable iff (reset_i)
    amo_we_i |-> !(accept_o && is_store));

endmodule

//--- logic/resp_align.sv
`include "mem_defines.svh"

module resp_align (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               accept_i,
  input  mem_pkg::opcode_e   op_i,
  input  logic [1:0]         off_i,
  input  logic [`LANES-1:0]  mask_i,
  input  logic [`DATA_W-1:0] reqdata_i,
  input  logic [`ADDR_W-3:0] idx_i,
  input  logic [7:0]         lane_rdata_i [`LANES],
  input  logic               yumi_i,
  output logic               stall_o,
  output logic               amo_we_o,
  output logic [`ADDR_W-3:0] amo_idx_o,
  output logic [`DATA_W-1:0] amo_word_o,
  output logic               v_o,
  output logic [`DATA_W-1:0] data_o
);

  logic               fly_v_r;
  logic               fly_adv;
  logic               is_amo;
  logic [`DATA_W-1:0] old_word;
  logic [`DATA_W-1:0] mask_word;
  logic [`DATA_W-1:0] result;
  logic [`DATA_W-1:0] new_word;
  logic [7:0]         byte_sel;
  logic [15:0]        half_sel;

  always_comb begin
    for (int i = 0; i < `LANES; i++) begin
      old_word[8*i +: 8]  = lane_rdata_i[i];
      mask_word[8*i +: 8] = {8{mask_i[i]}};
    end
  end

  assign byte_sel = old_word[8*off_i +: 8];
  assign half_sel = old_word[16*off_i[1] +: 16];

  // response word, stores answer zero
  always_comb begin
    is_amo = 1'b0;
    case (op_i)
      mem_pkg::LW:  result = old_word;
      mem_pkg::LH:  result = {{16{half_sel[15]}}, half_sel};
      mem_pkg::LB:  result = {{24{byte_sel[7]}}, byte_sel};
      mem_pkg::LHU: result = {16'b0, half_sel};
      mem_pkg::LBU: result = {24'b0, byte_sel};
      mem_pkg::LM:  result = old_word & mask_word;
      mem_pkg::AMOSWAP, mem_pkg::AMOADD, mem_pkg::AMOXOR, mem_pkg::AMOAND,
      mem_pkg::AMOOR, mem_pkg::AMOMIN, mem_pkg::AMOMAX, mem_pkg::AMOMINU,
      mem_pkg::AMOMAXU: begin
        is_amo = 1'b1;
        result = old_word;
      end
      default: result = '0;
    endcase
  end

  always_comb begin
    case (op_i)
      mem_pkg::AMOSWAP: new_word = reqdata_i;
      mem_pkg::AMOADD:  new_word = reqdata_i + old_word;
      mem_pkg::AMOXOR:  new_word = reqdata_i ^ old_word;
      mem_pkg::AMOAND:  new_word = reqdata_i & old_word;
      mem_pkg::AMOOR:   new_word = reqdata_i | old_word;
      mem_pkg::AMOMIN:
        new_word = ($signed(reqdata_i) < $signed(old_word)) ? reqdata_i : old_word;
      mem_pkg::AMOMAX:
        new_word = ($signed(reqdata_i) > $signed(old_word)) ? reqdata_i : old_word;
      mem_pkg::AMOMINU: new_word = (reqdata_i < old_word) ? reqdata_i : old_word;
      mem_pkg::AMOMAXU: new_word = (reqdata_i > old_word) ? reqdata_i : old_word;
      default:          new_word = old_word;
    endcase
  end

  // in-flight item moves on when the output register frees up
  assign fly_adv    = fly_v_r & (~v_o | yumi_i);
  assign stall_o    = (v_o & ~yumi_i) | (fly_v_r & is_amo);
  assign amo_we_o   = fly_adv & is_amo;
  assign amo_idx_o  = idx_i;
  assign amo_word_o = new_word;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fly_v_r <= 1'b0;
      v_o     <= 1'b0;
    end else begin
      if (accept_i) begin
        fly_v_r <= 1'b1;
      end else if (fly_adv) begin
        fly_v_r <= 1'b0;
      end
      if (fly_adv) begin
        v_o <= 1'b1;
      end else if (yumi_i) begin
        v_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fly_adv) begin
      data_o <= result;
    end
  end

  a_hold_out: assert property (@(posedge clk_i) disable iff (reset_i)
    (v_o && !yumi_i) |=> (v_o && $stable(data_o)));

endmodule

//--- logic/word_mem_top.sv
`include "mem_defines.svh"

module word_mem_top (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               v_i,
  input  mem_pkg::opcode_e   opcode_i,
  input  logic [`ADDR_W-1:0] addr_i,
  input  logic [`DATA_W-1:0] data_i,
  input  logic [`LANES-1:0]  mask_i,
  input  logic               yumi_i,
  output logic               ready_o,
  output logic               v_o,
  output logic [`DATA_W-1:0] data_o
);

  logic               accept;
  logic               lane_we [`LANES];
  mem_pkg::word_u     lane_wdata;
  logic [7:0]         lane_rdata [`LANES];
  logic [`ADDR_W-3:0] rd_idx;
  logic [`ADDR_W-3:0] wr_idx;
  logic [`ADDR_W-3:0] idx;
  mem_pkg::opcode_e   op;
  logic [1:0]         off;
  logic [`LANES-1:0]  mask;
  logic [`DATA_W-1:0] reqdata;
  logic               stall;
  logic               amo_we;
  logic [`ADDR_W-3:0] amo_idx;
  logic [`DATA_W-1:0] amo_word;

  req_decode req_decode_inst (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .v_i          (v_i),
    .opcode_i     (opcode_i),
    .addr_i       (addr_i),
    .data_i       (data_i),
    .mask_i       (mask_i),
    .stall_i      (stall),
    .amo_we_i     (amo_we),
    .amo_idx_i    (amo_idx),
    .amo_word_i   (amo_word),
    .ready_o      (ready_o),
    .accept_o     (accept),
    .lane_we_o    (lane_we),
    .lane_wdata_o (lane_wdata),
    .rd_idx_o     (rd_idx),
    .wr_idx_o     (wr_idx),
    .idx_o        (idx),
    .op_o         (op),
    .off_o        (off),
    .mask_o       (mask),
    .reqdata_o    (reqdata)
  );

  for (genvar i = 0; i < `LANES; i++) begin : g_lane
    byte_lane byte_lane_inst (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .re_i     (accept),
      .rd_idx_i (rd_idx),
      .we_i     (lane_we[i]),
      .wr_idx_i (wr_idx),
      .wdata_i  (lane_wdata.word[8*i +: 8]),
      .rdata_o  (lane_rdata[i])
    );
  end

  resp_align resp_align_inst (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .accept_i     (accept),
    .op_i         (op),
    .off_i        (off),
    .mask_i       (mask),
    .reqdata_i    (reqdata),
    .idx_i        (idx),
    .lane_rdata_i (lane_rdata),
    .yumi_i       (yumi_i),
    .stall_o      (stall),
    .amo_we_o     (amo_we),
    .amo_idx_o    (amo_idx),
    .amo_word_o   (amo_word),
    .v_o          (v_o),
    .data_o       (data_o)
  );

endmodule

//--- sources.f
+incdir+logic
logic/mem_pkg.sv
logic/byte_lane.sv
logic/req_decode.sv
logic/resp_align.sv
logic/word_mem_top.sv
tb/mem_checker.sv
tb/tb_top.sv

//--- tb/mem_checker.sv
`include "mem_defines.svh"

module mem_checker (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               req_v_i,
  input  logic               ready_i,
  input  mem_pkg::opcode_e   opcode_i,
  input  logic [`ADDR_W-1:0] addr_i,
  input  logic [`DATA_W-1:0] data_i,
  input  logic [`LANES-1:0]  mask_i,
  input  logic               resp_v_i,
  input  logic [`DATA_W-1:0] resp_data_i,
  input  logic               yumi_i,
  output int                 pending_o,
  output int                 errors_o,
  output int                 checks_o
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [`DATA_W-1:0] shadow [`MEM_WORDS];
  logic [`DATA_W-1:0] expect_q [$];
  string              test_name = "none";
  int                 test_checks = 0;
  int                 test_errors = 0;
  int                 err_total = 0;
  int                 check_total = 0;
  int                 accepts = 0;
  int                 responses = 0;

  assign errors_o = err_total;
  assign checks_o = check_total;

  // updates the shadow word and returns what the DUT should answer
  function automatic logic [`DATA_W-1:0] model(mem_pkg::opcode_e op, logic [`ADDR_W-1:0] addr,
                                               logic [`DATA_W-1:0] data, logic [`LANES-1:0] mask);
    logic [`ADDR_W-3:0] idx;
    logic [1:0]         off;
    logic [31:0]        old;
    logic [31:0]        upd;
    logic [31:0]        ret;
    logic [15:0]        half;
    logic [7:0]         byt;
    idx  = addr[`ADDR_W-1:2];
    off  = addr[1:0];
    old  = shadow[idx];
    upd  = old;
    ret  = old;
    half = 16'(old >> (16 * off[1]));
    byt  = 8'(old >> (8 * off));
    case (op)
      mem_pkg::LH:  ret = 32'($signed(half));
      mem_pkg::LB:  ret = 32'($signed(byt));
      mem_pkg::LHU: ret = 32'(half);
      mem_pkg::LBU: ret = 32'(byt);
      mem_pkg::LM: begin
        ret = '0;
        for (int b = 0; b < 4; b++) begin
          if (mask[b]) ret[8*b +: 8] = old[8*b +: 8];
        end
      end
      mem_pkg::SW: upd = data;
      mem_pkg::SH: upd[16*off[1] +: 16] = data[15:0];
      mem_pkg::SB: upd[8*off +: 8] = data[7:0];
      mem_pkg::SM: begin
        for (int b = 0; b < 4; b++) begin
          if (mask[b]) upd[8*b +: 8] = data[8*b +: 8];
        end
      end
      mem_pkg::AMOSWAP: upd = data;
      mem_pkg::AMOADD:  upd = old + data;
      mem_pkg::AMOXOR:  upd = old ^ data;
      mem_pkg::AMOAND:  upd = old & data;
      mem_pkg::AMOOR:   upd = old | data;
      mem_pkg::AMOMIN:  upd = ($signed(data) < $signed(old)) ? data : old;
      mem_pkg::AMOMAX:  upd = ($signed(data) > $signed(old)) ? data : old;
      mem_pkg::AMOMINU: upd = (data < old) ? data : old;
      mem_pkg::AMOMAXU: upd = (data > old) ? data : old;
      default: ;
    endcase
    if (op inside {mem_pkg::SW, mem_pkg::SH, mem_pkg::SB, mem_pkg::SM}) ret = '0;
    shadow[idx] = upd;
    return ret;
  endfunction

  task automatic report_error(string what);
    $display("ERROR in %s at %0t: %s", test_name, $time, what);
    test_errors++;
    err_total++;
  endtask

  task automatic compare(logic [`DATA_W-1:0] exp, logic [`DATA_W-1:0] act);
    test_checks++;
    check_total++;
    if (act !== exp) begin
      $display("FAIL %s expected %08h actual %08h", test_name, exp, act);
      test_errors++;
      err_total++;
    end
  endtask

  task automatic begin_test(string name);
    test_name   = name;
    test_checks = 0;
    test_errors = 0;
    accepts     = 0;
    responses   = 0;
  endtask

  task automatic end_test();
    $display("test %-10s %0d checks, %0d errors", test_name, test_checks, test_errors);
  endtask

  task automatic check_balance();
    test_checks++;
    check_total++;
    if (accepts != responses) begin
      $display("FAIL %s expected %0d responses actual %0d", test_name, accepts, responses);
      test_errors++;
      err_total++;
    end
  endtask

  // sampled mid-cycle, everything here settles before the falling edge
  always @(negedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `MEM_WORDS; i++) begin
        shadow[i] = '0;
      end
      expect_q.delete();
      test_checks++;
      check_total++;
      if (resp_v_i !== 1'b0 || ready_i !== 1'b0) begin
        report_error("v_o or ready_o is high during reset");
      end
    end else begin
      if (resp_v_i && yumi_i) begin
        responses++;
        if (expect_q.size() == 0) begin
          report_error("response consumed with no request outstanding");
        end else begin
          compare(expect_q.pop_front(), resp_data_i);
        end
      end
      if (req_v_i && ready_i) begin
        accepts++;
        expect_q.push_back(model(opcode_i, addr_i, data_i, mask_i));
      end
    end
    pending_o = expect_q.size();
  end

endmodule

//--- tb/tb_top.sv
`include "mem_defines.svh"

module tb_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD = 4;
  localparam int N_RESET    = `MEM_WORDS;
  localparam int N_SUBWORD  = 30;
  localparam int N_MASKED   = 20;
  localparam int N_AMO      = 27;
  localparam int N_STRESS   = 150;
  localparam int N_PAIRS    = 40;
  // requests issued over the whole run
  localparam int TOTAL_REQS = N_RESET + 2 * N_SUBWORD + 2 * N_MASKED + 3 * N_AMO
                            + N_STRESS + 2 * N_PAIRS;

  logic               clk_i;
  logic               reset_i;
  logic               v_i;
  mem_pkg::opcode_e   opcode_i;
  logic [`ADDR_W-1:0] addr_i;
  logic [`DATA_W-1:0] data_i;
  logic [`LANES-1:0]  mask_i;
  logic               yumi_i;
  logic               ready_o;
  logic               v_o;
  logic [`DATA_W-1:0] data_o;
  int                 pending;
  int                 errors;
  int                 checks;
  logic               gaps_on;
  logic               stretch_on;
  int                 hold_left;

  // loads 0..5, stores 6..9, atomics 10..18
  mem_pkg::opcode_e all_ops [19] = '{
    mem_pkg::LB, mem_pkg::LH, mem_pkg::LW, mem_pkg::LBU, mem_pkg::LHU, mem_pkg::LM,
    mem_pkg::SB, mem_pkg::SH, mem_pkg::SW, mem_pkg::SM,
    mem_pkg::AMOSWAP, mem_pkg::AMOADD, mem_pkg::AMOXOR, mem_pkg::AMOAND, mem_pkg::AMOOR,
    mem_pkg::AMOMIN, mem_pkg::AMOMAX, mem_pkg::AMOMINU, mem_pkg::AMOMAXU
  };

  word_mem_top word_mem_top_inst (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .v_i      (v_i),
    .opcode_i (opcode_i),
    .addr_i   (addr_i),
    .data_i   (data_i),
    .mask_i   (mask_i),
    .yumi_i   (yumi_i),
    .ready_o  (ready_o),
    .v_o      (v_o),
    .data_o   (data_o)
  );

  mem_checker mem_checker_inst (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_v_i     (v_i),
    .ready_i     (ready_o),
    .opcode_i    (opcode_i),
    .addr_i      (addr_i),
    .data_i      (data_i),
    .mask_i      (mask_i),
    .resp_v_i    (v_o),
    .resp_data_i (data_o),
    .yumi_i      (yumi_i),
    .pending_o   (pending),
    .errors_o    (errors),
    .checks_o    (checks)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    #(TOTAL_REQS * 20 * CLK_PERIOD);
    $display("timeout: run did not finish within %0d cycles", TOTAL_REQS * 20);
    $display("=== FAIL ===");
    $finish;
  end

  // yumi is random, with long low stretches while stretch_on is set
  initial begin
    forever begin
      @(posedge clk_i);
      if (hold_left > 0) begin
        hold_left--;
        yumi_i <= 1'b0;
      end else if (stretch_on && $urandom_range(5) == 0) begin
        hold_left = $urandom_range(12, 1);
        yumi_i <= 1'b0;
      end else begin
        yumi_i <= ($urandom_range(3) != 0);
      end
    end
  end

  // word index within the first 16 words, offset aligned to the access size
  function automatic logic [`ADDR_W-1:0] pick_addr(mem_pkg::opcode_e op, logic [3:0] idx);
    logic [1:0] off;
    off = 2'($urandom_range(3));
    if (op inside {mem_pkg::LH, mem_pkg::LHU, mem_pkg::SH}) begin
      off[0] = 1'b0;
    end else if (!(op inside {mem_pkg::LB, mem_pkg::LBU, mem_pkg::SB})) begin
      off = 2'b00;
    end
    return {2'b00, idx, off};
  endfunction

  task automatic issue(mem_pkg::opcode_e op, logic [`ADDR_W-1:0] addr,
                       logic [`DATA_W-1:0] data, logic [`LANES-1:0] mask);
    while (gaps_on && $urandom_range(3) == 0) begin
      v_i <= 1'b0;
      @(posedge clk_i);
    end
    v_i      <= 1'b1;
    opcode_i <= op;
    addr_i   <= addr;
    data_i   <= data;
    mask_i   <= mask;
    // ready is looked at mid-cycle, the following edge takes the request
    @(negedge clk_i);
    while (!ready_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    v_i <= 1'b0;
  endtask

  task automatic drain();
    @(posedge clk_i);
    while (pending != 0) begin
      @(posedge clk_i);
    end
  endtask

  initial begin
    logic [3:0]       idx;
    mem_pkg::opcode_e op;
    reset_i    = 1'b1;
    v_i        = 1'b0;
    opcode_i   = mem_pkg::LW;
    addr_i     = '0;
    data_i     = '0;
    mask_i     = '0;
    yumi_i     = 1'b0;
    gaps_on    = 1'b1;
    stretch_on = 1'b0;
    hold_left  = 0;
    void'($urandom(32'h29bd_585f));

    mem_checker_inst.begin_test("reset");
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;
    for (int i = 0; i < N_RESET; i++) begin
      issue(mem_pkg::LW, {i[5:0], 2'b00}, $urandom, 4'($urandom));
    end
    drain();
    mem_checker_inst.end_test();

    mem_checker_inst.begin_test("subword");
    for (int i = 0; i < N_SUBWORD; i++) begin
      idx = 4'($urandom_range(15));
      op  = all_ops[6 + $urandom_range(1)];
      issue(op, pick_addr(op, idx), $urandom, '0);
      op  = all_ops[$urandom_range(1) + 3 * $urandom_range(1)];
      issue(op, pick_addr(op, idx), $urandom, '0);
    end
    drain();
    mem_checker_inst.end_test();

    mem_checker_inst.begin_test("masked");
    for (int i = 0; i < N_MASKED; i++) begin
      idx = 4'($urandom_range(15));
      issue(mem_pkg::SM, {2'b00, idx, 2'b00}, $urandom, 4'($urandom));
      issue(mem_pkg::LM, {2'b00, idx, 2'b00}, $urandom, 4'($urandom));
    end
    drain();
    mem_checker_inst.end_test();

    mem_checker_inst.begin_test("atomics");
    for (int i = 0; i < N_AMO; i++) begin
      idx = 4'($urandom_range(15));
      issue(mem_pkg::SW, {2'b00, idx, 2'b00}, $urandom, '0);
      issue(all_ops[10 + i % 9], {2'b00, idx, 2'b00}, $urandom, '0);
      issue(mem_pkg::LW, {2'b00, idx, 2'b00}, $urandom, '0);
    end
    drain();
    mem_checker_inst.end_test();

    mem_checker_inst.begin_test("backpress");
    stretch_on = 1'b1;
    for (int i = 0; i < N_STRESS; i++) begin
      op = all_ops[$urandom_range(18)];
      issue(op, pick_addr(op, 4'($urandom_range(15))), $urandom, 4'($urandom));
    end
    drain();
    stretch_on = 1'b0;
    mem_checker_inst.check_balance();
    mem_checker_inst.end_test();

    // store followed at once by a load or atomic on the same word
    mem_checker_inst.begin_test("back2back");
    gaps_on = 1'b0;
    for (int i = 0; i < N_PAIRS; i++) begin
      idx = 4'($urandom_range(15));
      op  = all_ops[6 + $urandom_range(3)];
      issue(op, pick_addr(op, idx), $urandom, 4'($urandom));
      op  = $urandom_range(1) ? all_ops[$urandom_range(5)] : all_ops[10 + $urandom_range(8)];
      issue(op, pick_addr(op, idx), $urandom, 4'($urandom));
    end
    drain();
    mem_checker_inst.end_test();

    $display("tests: 6, checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
